//--- dram_sequencer.sv
// accepts a command only in IDLE; refresh is CAS-before-RAS on both chips with no done pulse
`timescale 1ns/100ps
`default_nettype none
`include "zmem_defines.svh"

module dram_sequencer import zmem_pkg::*;
(
	input  logic                  fclk,
	input  logic                  reset,
	input  dram_cmd_t             cmd,
	input  logic [`ZM_DRAM_W-1:0] rd_in,
	output logic [`ZM_RA_W-1:0]   ra,
	output logic [`ZM_DRAM_W-1:0] rd_out,
	output logic                  rd_oe,
	output logic                  rwe_n,
	output logic                  rucas_n,
	output logic                  rlcas_n,
	output logic                  rras0_n,
	output logic                  rras1_n,
	output logic                  done,
	output logic [`ZM_DATA_W-1:0] rdata_byte
);

	typedef enum logic [2:0] {IDLE, RAS, CAS, PRE, REF_CAS, REF_RAS} seq_state_e;

	// last cycle index of each phase
	localparam logic [2:0] RCD_LAST = 3'(`ZM_TRCD - 1);
	localparam logic [2:0] CAS_LAST = 3'(`ZM_TCAS - 1);
	localparam logic [2:0] RP_LAST  = 3'(`ZM_TRP - 1);

	seq_state_e state;
	seq_state_e nxt_state;
	logic [2:0] cnt;
	dram_cmd_t  cur;
	logic       rw_ras;
	logic       rw_cas;
	logic       ref_cas;

	always_comb
	begin
		nxt_state = state;
		case (state)
			IDLE:
				if (cmd.valid)
					nxt_state = (cmd.op == op_ref) ? REF_CAS : RAS;
			RAS:
				if (cnt == RCD_LAST)
					nxt_state = CAS;
			CAS:
				if (cnt == CAS_LAST)
					nxt_state = PRE;
			PRE:
				if (cnt == RP_LAST)
					nxt_state = IDLE;
			REF_CAS:
				nxt_state = REF_RAS;
			REF_RAS:
				if (cnt == CAS_LAST)
					nxt_state = PRE;
			default:
				nxt_state = IDLE;
		endcase
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			state <= IDLE;
			cnt   <= '0;
		end
		else
		begin
			state <= nxt_state;
			if (state == IDLE || nxt_state != state)
				cnt <= '0;
			else
				cnt <= cnt + 3'd1;
		end
	end

	// command and read byte, latched where the FSM samples them
	always_ff @(posedge fclk)
	begin
		if (state == IDLE && cmd.valid)
			cur <= cmd;
		if (state == CAS && cnt == CAS_LAST && cur.op == op_rd)
			rdata_byte <= cur.lane_hi ? rd_in[15:8] : rd_in[7:0];
	end

	assign rw_ras  = state == RAS || state == CAS;
	assign rw_cas  = state == CAS;
	assign ref_cas = state == REF_CAS || state == REF_RAS;

	// row is already on ra in IDLE, column goes out on the last RAS cycle
	always_comb
	begin
		if (state == IDLE)
			ra = cmd.row;
		else if (state == RAS && cnt != RCD_LAST)
			ra = cur.row;
		else
			ra = cur.col;
	end

	assign rras0_n = !((rw_ras && !cur.chip) || state == REF_RAS);
	assign rras1_n = !((rw_ras && cur.chip) || state == REF_RAS);
	assign rlcas_n = !((rw_cas && !cur.lane_hi) || ref_cas);
	assign rucas_n = !((rw_cas && cur.lane_hi) || ref_cas);

	// same byte on both halves, only the selected lane is strobed
	assign rd_out = {cur.wdata, cur.wdata};
	assign rd_oe  = rw_cas && cur.op == op_wr;
	assign rwe_n  = !(rw_cas && cur.op == op_wr);

	assign done = state == PRE && cnt == RP_LAST && cur.op != op_ref;

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
zmem_pkg.sv
zbus_sampler.sv
mem_pager.sv
dram_sequencer.sv
zbus_responder.sv
zmem_top.sv
zmem_chk.sv
tb_zmem.sv

//--- mem_pager.sv
// writes below 0x4000 are dropped; once lock is set the page register holds until reset
`timescale 1ns/100ps
`default_nettype none
`include "zmem_defines.svh"

module mem_pager import zmem_pkg::*;
(
	input  logic        fclk,
	input  logic        reset,
	input  zbus_req_t   req,
	output dram_cmd_t   cmd,
	output mem_target_e target,
	output logic        hit,
	output logic        rom_page
);

	page_reg_t   page;
	logic [3:0]  bank;
	logic [17:0] byte_addr;
	logic        page_wr;
	logic        nxt_hit;
	dram_cmd_t   nxt_cmd;
	mem_target_e nxt_target;

	assign page_wr = req.valid && req.kind == io_wr &&
		{req.addr.io.port_hi, req.addr.io.port_lo} == `ZM_PAGE_PORT;

	// window 0 is rom, bank is unused there
	always_comb
	begin
		case (req.addr.mem.page_sel)
			2'd1: bank = 4'(`ZM_BANK_WIN1);
			2'd2: bank = 4'(`ZM_BANK_WIN2);
			default: bank = page.bank;
		endcase
	end

	// byte address split: chip, row, col, then lane in bit 0
	assign byte_addr = {bank, req.addr.mem.offset};

	always_comb
	begin
		nxt_cmd         = '0;
		nxt_cmd.chip    = byte_addr[17];
		nxt_cmd.row     = byte_addr[16:9];
		nxt_cmd.col     = byte_addr[8:1];
		nxt_cmd.lane_hi = byte_addr[0];
		nxt_cmd.wdata   = req.wdata;
		nxt_target      = tgt_none;
		nxt_hit         = 1'b0;
		if (req.valid)
		begin
			case (req.kind)
				mem_rd, mem_wr:
				begin
					if (req.addr.mem.page_sel == 2'd0)
					begin
						if (req.kind == mem_rd)
						begin
							nxt_target = tgt_rom;
							nxt_hit    = 1'b1;
						end
					end
					else
					begin
						nxt_target    = tgt_dram;
						nxt_hit       = 1'b1;
						nxt_cmd.valid = 1'b1;
						nxt_cmd.op    = (req.kind == mem_rd) ? op_rd : op_wr;
					end
				end
				refresh:
				begin
					nxt_target    = tgt_refresh;
					nxt_hit       = 1'b1;
					nxt_cmd.valid = 1'b1;
					nxt_cmd.op    = op_ref;
				end
				default:
					nxt_hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge fclk)
	begin
		cmd    <= nxt_cmd;
		target <= nxt_target;
		if (reset)
		begin
			cmd.valid <= 1'b0;
			hit       <= 1'b0;
			page      <= '0;
		end
		else
		begin
			hit <= nxt_hit;
			if (page_wr && !page.lock)
				page <= page_reg_t'(req.wdata[5:0]);
		end
	end

	assign rom_page = page.rom_sel;

endmodule

`default_nettype wire

//--- tb_zmem.sv
// Z80 cycles use fixed minimum T-state holds; reads only check addresses written earlier in the run
`timescale 1ns/100ps
`default_nettype none
`include "zmem_defines.svh"

module tb_zmem;

	localparam int K_RD = 0;
	localparam int K_WR = 1;
	localparam int K_IOW = 2;
	localparam int K_REF = 3;
	localparam int MIN_HOLD = 10;
	localparam int IDLE_GAP = 4;
	localparam int MAX_CYCLES = 4000;

	logic        fclk = 1'b0;
	logic        reset;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic [7:0]  d_out;
	logic        d_oe;
	logic        mreq_n, iorq_n, rd_n, wr_n, rfsh_n;
	logic        wait_n;
	logic [7:0]  rom_d;
	logic        csrom, romoe_n, rom_page;
	logic [7:0]  ra;
	logic [15:0] rd_in;
	logic [15:0] rd_out;
	logic        rd_oe, rwe_n, rucas_n, rlcas_n, rras0_n, rras1_n;

	// memory models and the shadow state of the reference
	logic [7:0]  rom_mem [32768];
	logic [15:0] dram0 [65536];
	logic [15:0] dram1 [65536];
	logic [7:0]  row0, row1;
	logic [3:0]  pins_q = 4'hf;
	logic [15:0] m_idx;
	logic [15:0] m_word;
	logic [7:0]  shadow [262144];
	logic [3:0]  sh_bank;
	logic        sh_rom;
	logic        sh_lock;

	logic [7:0]  exp_q [$];
	logic [7:0]  got_q [$];
	logic [15:0] addr_q [$];
	logic [15:0] written [$];
	int          errors = 0;
	int          compared = 0;
	int          cycles = 0;
	integer      seed;
	logic [31:0] r;
	logic [15:0] addr;

	zmem_top u_dut (.*);

	always #20 fclk = ~fclk;

	assign rom_d = rom_mem[{rom_page, a[13:0]}];

	// row latched on RAS fall, access on CAS fall, sampled just after the clock edge
	always @(posedge fclk)
	begin
		#2;
		if (!rras0_n && pins_q[0])
			row0 = ra;
		if (!rras1_n && pins_q[1])
			row1 = ra;
		if (((!rlcas_n && pins_q[2]) || (!rucas_n && pins_q[3])) && (!rras0_n || !rras1_n))
		begin
			m_idx = {rras0_n ? row1 : row0, ra};
			m_word = rras0_n ? dram1[m_idx] : dram0[m_idx];
			if (!rwe_n)
			begin
				if (!rd_oe)
				begin
					errors++;
					$display("DRAM write strobed while rd_oe was not driving the data bus");
				end
				if (!rlcas_n)
					m_word[7:0] = rd_out[7:0];
				if (!rucas_n)
					m_word[15:8] = rd_out[15:8];
				if (rras0_n)
					dram1[m_idx] = m_word;
				else
					dram0[m_idx] = m_word;
			end
			else
				rd_in = m_word;
		end
		pins_q = {rucas_n, rlcas_n, rras1_n, rras0_n};
	end

	function automatic logic [7:0] rom_pattern(input logic [14:0] i);
		return i[7:0] ^ {1'b0, i[14:8]} ^ 8'h3c;
	endfunction

	function automatic logic [3:0] map_bank(input logic [15:0] ad);
		case (ad[15:14])
			2'd1: return 4'(`ZM_BANK_WIN1);
			2'd2: return 4'(`ZM_BANK_WIN2);
			default: return sh_bank;
		endcase
	endfunction

	// expected read byte from the shadow page register and memory
	function automatic logic [7:0] exp_read(input logic [15:0] ad);
		if (ad[15:14] == 2'd0)
			return rom_pattern({sh_rom, ad[13:0]});
		return shadow[{map_bank(ad), ad[13:0]}];
	endfunction

	// byte in the DRAM model at chip, row, col and lane
	function automatic logic [7:0] model_byte(input logic [17:0] b);
		logic [15:0] word;
		word = b[17] ? dram1[b[16:1]] : dram0[b[16:1]];
		return b[0] ? word[15:8] : word[7:0];
	endfunction

	task automatic bus_cycle(input int kind, input logic [15:0] ad, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int         held;
		logic       dram;
		logic       finished;
		logic       saw_wait;
		logic [1:0] ras_seen;
		logic [1:0] cas_seen;
		held = 0;
		finished = 1'b0;
		saw_wait = 1'b0;
		ras_seen = 2'b00;
		cas_seen = 2'b00;
		rdata = 8'h00;
		dram = (kind == K_RD || kind == K_WR) && ad[15:14] != 2'd0;
		@(posedge fclk);
		#2;
		a = ad;
		d_in = wdata;
		mreq_n = kind == K_IOW;
		iorq_n = kind != K_IOW;
		rd_n = kind != K_RD;
		wr_n = !(kind == K_WR || kind == K_IOW);
		rfsh_n = kind != K_REF;
		while (!finished)
		begin
			@(negedge fclk);
			held++;
			if (!wait_n)
				saw_wait = 1'b1;
			ras_seen |= ~{rras1_n, rras0_n};
			cas_seen |= ~{rucas_n, rlcas_n};
			if (!rwe_n && kind != K_WR)
			begin
				errors++;
				$display("write enable asserted during a non-write bus cycle at %h", ad);
			end
			if (kind == K_RD)
				finished = wait_n && d_oe;
			else
				finished = held >= MIN_HOLD && wait_n;
		end
		if (kind == K_RD)
			rdata = d_out;
		if (kind == K_RD && !dram && (!csrom || romoe_n || ras_seen != 2'b00))
		begin
			errors++;
			$display("ROM read at %h missed csrom or touched a RAS line", ad);
		end
		if (saw_wait != dram)
		begin
			errors++;
			$display("wait_n behaved wrongly for the access at %h (asserted=%0d)", ad, saw_wait);
		end
		if (kind == K_REF && (ras_seen != 2'b11 || cas_seen != 2'b11))
		begin
			errors++;
			$display("refresh did not strobe RAS and CAS on both chips");
		end
		@(posedge fclk);
		#2;
		{mreq_n, iorq_n, rd_n, wr_n, rfsh_n} = 5'b11111;
		repeat (IDLE_GAP) @(posedge fclk);
	endtask

	task automatic mem_write(input logic [15:0] ad, input logic [7:0] data);
		logic [7:0]  dummy;
		logic [17:0] baddr;
		bus_cycle(K_WR, ad, data, dummy);
		baddr = {map_bank(ad), ad[13:0]};
		shadow[baddr] = data;
		if (model_byte(baddr) !== data)
		begin
			errors++;
			$display("ERROR dram_model addr=%h got=%h exp=%h", baddr, model_byte(baddr), data);
		end
	endtask

	task automatic mem_read(input logic [15:0] ad);
		logic [7:0] data;
		bus_cycle(K_RD, ad, 8'h00, data);
		exp_q.push_back(exp_read(ad));
		got_q.push_back(data);
		addr_q.push_back(ad);
	endtask

	task automatic page_write(input logic [7:0] data);
		logic [7:0] dummy;
		bus_cycle(K_IOW, `ZM_PAGE_PORT, data, dummy);
		if (!sh_lock)
			{sh_lock, sh_rom, sh_bank} = data[5:0];
		if (rom_page !== sh_rom)
		begin
			errors++;
			$display("ERROR rom_page got=%h exp=%h", rom_page, sh_rom);
		end
	endtask

	// compares each returned read byte with the reference
	always @(posedge fclk)
	begin
		if (got_q.size() > 0)
		begin
			if (got_q[0] !== exp_q[0])
			begin
				errors++;
				$display("ERROR d_out addr=%h got=%h exp=%h", addr_q[0], got_q[0], exp_q[0]);
			end
			void'(got_q.pop_front());
			void'(exp_q.pop_front());
			void'(addr_q.pop_front());
			compared++;
		end
	end

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish in %0d cycles, %0d errors", cycles, errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		seed = 96;
		reset = 1'b1;
		a = '0;
		d_in = '0;
		{mreq_n, iorq_n, rd_n, wr_n, rfsh_n} = 5'b11111;
		rd_in = '0;
		{sh_lock, sh_rom, sh_bank} = 6'd0;
		for (int i = 0; i < 32768; i++)
			rom_mem[i] = rom_pattern(15'(i));
		repeat (8) @(posedge fclk);
		#2;
		reset = 1'b0;
		// quiet bus after reset
		repeat (10)
		begin
			@(negedge fclk);
			if ({wait_n, rras0_n, rras1_n, rlcas_n, rucas_n, rwe_n, romoe_n, d_oe, rd_oe, csrom}
				!== 10'b1111111000)
			begin
				errors++;
				$display("ERROR idle_lines got=%h exp=%h", {wait_n, rras0_n, rras1_n, rlcas_n,
					rucas_n, rwe_n, romoe_n, d_oe, rd_oe, csrom}, 10'b1111111000);
			end
		end
		// fixed windows at banks 5 and 2
		for (int i = 0; i < 12; i++)
		begin
			r = $random(seed);
			addr = {(i % 2 == 0) ? 2'b01 : 2'b10, r[13:0]};
			mem_write(addr, r[23:16]);
			written.push_back(addr);
		end
		foreach (written[i])
			mem_read(written[i]);
		// paged window at 0xC000
		for (int b = 0; b < 4; b++)
		begin
			page_write(8'(b * 4 + 1));
			mem_write(16'hC155, 8'(8'h30 + b));
		end
		for (int b = 0; b < 4; b++)
		begin
			page_write(8'(b * 4 + 1));
			mem_read(16'hC155);
		end
		mem_read(16'h4155);
		// ROM pages
		for (int i = 0; i < 4; i++)
			mem_read(16'(i * 16'h0e35 + 16'h0123));
		page_write(8'h13);
		for (int i = 0; i < 4; i++)
			mem_read(16'(i * 16'h0e35 + 16'h0123));
		// lock holds the mapping
		page_write(8'h27);
		mem_write(16'hC123, 8'h9a);
		page_write(8'h1b);
		mem_read(16'hC123);
		mem_read(16'h0123);
		// refresh keeps memory intact
		for (int i = 0; i < 6; i++)
		begin
			r = $random(seed);
			bus_cycle(K_REF, r[15:0], 8'h00, r[7:0]);
		end
		foreach (written[i])
			mem_read(written[i]);
		while (got_q.size() != 0)
			@(posedge fclk);
		repeat (2) @(posedge fclk);
		$display("run complete: %0d reads compared, %0d errors, %0d assertion failures",
			compared, errors, u_dut.u_seq.u_chk.fails);
		if (errors == 0 && u_dut.u_seq.u_chk.fails == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- zbus_responder.sv
// d_oe follows the synchronized rd strobe, so the bus is released 2 fclk after rd_n rises
`timescale 1ns/100ps
`default_nettype none
`include "zmem_defines.svh"

module zbus_responder import zmem_pkg::*;
(
	input  logic                  fclk,
	input  logic                  reset,
	input  mem_target_e           target,
	input  logic                  hit,
	input  logic                  rd_active,
	input  logic                  done,
	input  logic [`ZM_DATA_W-1:0] rdata_byte,
	input  logic [`ZM_DATA_W-1:0] rom_d,
	output logic                  wait_n,
	output logic [`ZM_DATA_W-1:0] d_out,
	output logic                  d_oe,
	output logic                  csrom,
	output logic                  romoe_n
);

	mem_target_e           cur_tgt;
	logic                  dram_rdy;
	logic [`ZM_DATA_W-1:0] dram_byte;

	// wait only for DRAM, held until the sequencer is done
	always_ff @(posedge fclk)
	begin
		if (reset)
			wait_n <= 1'b1;
		else if (done)
			wait_n <= 1'b1;
		else if (hit && target == tgt_dram)
			wait_n <= 1'b0;
	end

	// target lives until the read strobe ends and no wait is pending
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			cur_tgt  <= tgt_none;
			dram_rdy <= 1'b0;
		end
		else
		begin
			if (hit)
				cur_tgt <= target;
			else if (!rd_active && wait_n)
				cur_tgt <= tgt_none;

			if (done)
				dram_rdy <= 1'b1;
			else if (hit)
				dram_rdy <= 1'b0;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (done)
			dram_byte <= rdata_byte;
	end

	assign csrom   = cur_tgt == tgt_rom;
	assign romoe_n = !csrom;

	// rom data passes straight through, DRAM data from the latch
	assign d_out = csrom ? rom_d : dram_byte;
	assign d_oe  = rd_active && (csrom || (cur_tgt == tgt_dram && dram_rdy));

endmodule

`default_nettype wire

//--- zbus_sampler.sv
// strobes are async to fclk; a and d_in must hold stable for the whole strobe, iorq reads are dropped
`timescale 1ns/100ps
`default_nettype none
`include "zmem_defines.svh"

module zbus_sampler import zmem_pkg::*;
(
	input  logic                  fclk,
	input  logic                  reset,
	input  logic [`ZM_ADDR_W-1:0] a,
	input  logic [`ZM_DATA_W-1:0] d_in,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  rfsh_n,
	output zbus_req_t             req,
	output logic                  rd_active
);

	// strobes as active high, order mreq iorq rd wr rfsh
	logic [4:0] strb_pin;
	logic [4:0] strb_sync [`ZM_SYNC_STAGES];
	logic       mreq_s;
	logic       iorq_s;
	logic       rd_s;
	logic       wr_s;
	logic       rfsh_s;
	logic       fire;
	logic       busy;
	zbus_kind_e kind;

	assign strb_pin = ~{mreq_n, iorq_n, rd_n, wr_n, rfsh_n};

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `ZM_SYNC_STAGES; i++)
				strb_sync[i] <= '0;
		end
		else
		begin
			strb_sync[0] <= strb_pin;
			for (int i = 1; i < `ZM_SYNC_STAGES; i++)
				strb_sync[i] <= strb_sync[i-1];
		end
	end

	assign {mreq_s, iorq_s, rd_s, wr_s, rfsh_s} = strb_sync[`ZM_SYNC_STAGES-1];

	// classify; refresh wins over a read
	always_comb
	begin
		fire = 1'b0;
		kind = mem_rd;
		if (mreq_s && rfsh_s)
		begin
			fire = 1'b1;
			kind = refresh;
		end
		else if (mreq_s && rd_s)
		begin
			fire = 1'b1;
			kind = mem_rd;
		end
		else if (mreq_s && wr_s)
		begin
			fire = 1'b1;
			kind = mem_wr;
		end
		else if (iorq_s && wr_s)
		begin
			fire = 1'b1;
			kind = io_wr;
		end
	end

	// one request per strobe, rearmed once mreq and iorq are both seen high
	always_ff @(posedge fclk)
	begin
		if (reset)
			busy <= 1'b0;
		else if (!mreq_s && !iorq_s)
			busy <= 1'b0;
		else if (fire)
			busy <= 1'b1;
	end

	always_ff @(posedge fclk)
	begin
		req.kind  <= kind;
		req.addr  <= a;
		req.wdata <= d_in;
		if (reset)
			req.valid <= 1'b0;
		else
			req.valid <= fire && !busy;
	end

	assign rd_active = mreq_s && rd_s && !rfsh_s;

endmodule

`default_nettype wire

//--- zmem_chk.sv
// assumes the sequencer FSM encodes IDLE as 0; checks pin order only, never data values
`timescale 1ns/100ps
`default_nettype none

module zmem_chk import zmem_pkg::*;
(
	input logic       fclk,
	input logic       reset,
	input dram_cmd_t  cmd,
	input logic [2:0] state,
	input logic       rwe_n,
	input logic       rucas_n,
	input logic       rlcas_n,
	input logic       rras0_n,
	input logic       rras1_n
);

	logic any_cas;
	logic any_ras;
	int   fails = 0;

	assign any_cas = !rlcas_n || !rucas_n;
	assign any_ras = !rras0_n || !rras1_n;

	// commands only reach an idle sequencer
	a_cmd_idle: assert property (@(posedge fclk) disable iff (reset)
		cmd.valid |-> state == 3'd0)
	else
	begin
		fails++;
		$error("DRAM command arrived while the sequencer was busy");
	end

	// refresh drops both CAS with no row open and both RAS a cycle later
	a_cbr: assert property (@(posedge fclk) disable iff (reset)
		($fell(rlcas_n) && $fell(rucas_n) && !any_ras) |=>
		(!rras0_n && !rras1_n && !rlcas_n && !rucas_n))
	else
	begin
		fails++;
		$error("refresh CAS not followed by RAS on both chips");
	end

	// a CAS fall needs exactly one open row, unless it starts a refresh
	a_ras_cas: assert property (@(posedge fclk) disable iff (reset)
		($fell(rlcas_n) || $fell(rucas_n)) |->
		((rras0_n != rras1_n) || (!rlcas_n && !rucas_n && !any_ras)))
	else
	begin
		fails++;
		$error("CAS fell without a RAS in front of it");
	end

	a_we: assert property (@(posedge fclk) disable iff (reset)
		!rwe_n |-> (any_cas && any_ras))
	else
	begin
		fails++;
		$error("rwe_n low outside the CAS phase");
	end

	// both RAS lines low together only inside a refresh
	a_ras_both: assert property (@(posedge fclk) disable iff (reset)
		(!rras0_n && !rras1_n) |-> (!rlcas_n && !rucas_n))
	else
	begin
		fails++;
		$error("both RAS lines low outside a refresh");
	end

endmodule

bind dram_sequencer zmem_chk u_chk (
	.fclk    (fclk),
	.reset   (reset),
	.cmd     (cmd),
	.state   (state),
	.rwe_n   (rwe_n),
	.rucas_n (rucas_n),
	.rlcas_n (rlcas_n),
	.rras0_n (rras0_n),
	.rras1_n (rras1_n)
);

`default_nettype wire

//--- zmem_defines.svh
// all counts are in fclk cycles; each DRAM phase must be between 1 and 7 cycles long
`ifndef ZMEM_DEFINES_SVH
`define ZMEM_DEFINES_SVH

// Z80 and DRAM bus widths
`define ZM_ADDR_W 16
`define ZM_DATA_W 8
`define ZM_DRAM_W 16
`define ZM_RA_W 8

// DRAM phase lengths
`define ZM_TRCD 2
`define ZM_TCAS 2
`define ZM_TRP 2

// memory map and paging
`define ZM_PAGE_PORT 16'h7FFD
`define ZM_BANK_WIN1 5
`define ZM_BANK_WIN2 2

`define ZM_SYNC_STAGES 2

`endif

//--- zmem_pkg.sv
// field order of page_reg_t follows the 7FFD data byte (bank in bits 3:0, rom in 4, lock in 5)
`default_nettype none
`include "zmem_defines.svh"

package zmem_pkg;

	typedef enum logic [1:0] {mem_rd, mem_wr, io_wr, refresh} zbus_kind_e;

	typedef struct packed {
		logic [1:0]  page_sel;
		logic [13:0] offset;
	} zbus_mem_addr_t;

	typedef struct packed {
		logic [7:0] port_hi;
		logic [7:0] port_lo;
	} zbus_io_addr_t;

	// memory location on mreq cycles, port number on iorq cycles
	typedef union packed {
		zbus_mem_addr_t mem;
		zbus_io_addr_t  io;
	} zbus_addr_u;

	typedef struct packed {
		zbus_kind_e                kind;
		zbus_addr_u                addr;
		logic [`ZM_DATA_W-1:0]     wdata;
		logic                      valid;
	} zbus_req_t;

	typedef enum logic [1:0] {tgt_none, tgt_rom, tgt_dram, tgt_refresh} mem_target_e;

	typedef enum logic [1:0] {op_rd, op_wr, op_ref} dram_op_e;

	typedef struct packed {
		logic                  valid;
		dram_op_e              op;
		logic                  chip;
		logic [7:0]            row;
		logic [7:0]            col;
		logic                  lane_hi;
		logic [`ZM_DATA_W-1:0] wdata;
	} dram_cmd_t;

	typedef struct packed {
		logic       lock;
		logic       rom_sel;
		logic [3:0] bank;
	} page_reg_t;

endpackage

`default_nettype wire

//--- zmem_top.sv
// data and DRAM buses are split into in, out and oe; tri-state buffers belong outside this block
`timescale 1ns/100ps
`default_nettype none
`include "zmem_defines.svh"

module zmem_top import zmem_pkg::*;
(
	input  logic                  fclk,
	input  logic                  reset,
	// Z80 bus
	input  logic [`ZM_ADDR_W-1:0] a,
	input  logic [`ZM_DATA_W-1:0] d_in,
	output logic [`ZM_DATA_W-1:0] d_out,
	output logic                  d_oe,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  rfsh_n,
	output logic                  wait_n,
	// ROM
	input  logic [`ZM_DATA_W-1:0] rom_d,
	output logic                  csrom,
	output logic                  romoe_n,
	output logic                  rom_page,
	// DRAM
	output logic [`ZM_RA_W-1:0]   ra,
	input  logic [`ZM_DRAM_W-1:0] rd_in,
	output logic [`ZM_DRAM_W-1:0] rd_out,
	output logic                  rd_oe,
	output logic                  rwe_n,
	output logic                  rucas_n,
	output logic                  rlcas_n,
	output logic                  rras0_n,
	output logic                  rras1_n
);

	zbus_req_t             req;
	dram_cmd_t             cmd;
	mem_target_e           target;
	logic                  hit;
	logic                  rd_active;
	logic                  done;
	logic [`ZM_DATA_W-1:0] rdata_byte;

	zbus_sampler u_sampler (
		.fclk      (fclk),
		.reset     (reset),
		.a         (a),
		.d_in      (d_in),
		.mreq_n    (mreq_n),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.rfsh_n    (rfsh_n),
		.req       (req),
		.rd_active (rd_active)
	);

	mem_pager u_pager (
		.fclk     (fclk),
		.reset    (reset),
		.req      (req),
		.cmd      (cmd),
		.target   (target),
		.hit      (hit),
		.rom_page (rom_page)
	);

	dram_sequencer u_seq (
		.fclk       (fclk),
		.reset      (reset),
		.cmd        (cmd),
		.rd_in      (rd_in),
		.ra         (ra),
		.rd_out     (rd_out),
		.rd_oe      (rd_oe),
		.rwe_n      (rwe_n),
		.rucas_n    (rucas_n),
		.rlcas_n    (rlcas_n),
		.rras0_n    (rras0_n),
		.rras1_n    (rras1_n),
		.done       (done),
		.rdata_byte (rdata_byte)
	);

	zbus_responder u_resp (
		.fclk       (fclk),
		.reset      (reset),
		.target     (target),
		.hit        (hit),
		.rd_active  (rd_active),
		.done       (done),
		.rdata_byte (rdata_byte),
		.rom_d      (rom_d),
		.wait_n     (wait_n),
		.d_out      (d_out),
		.d_oe       (d_oe),
		.csrom      (csrom),
		.romoe_n    (romoe_n)
	);

endmodule

`default_nettype wire
